// File: rtl/i3c_target_params.svh
`ifndef I3C_TARGET_PARAMS_SVH
`define I3C_TARGET_PARAMS_SVH

// Static target address width
`define I3C_ADDR_W 7

// One bus byte
`define I3C_BYTE_W 8

// Hold delay counter, in clock cycles
`define I3C_TIMER_W 13

// Bit index covers 8 data bits plus the acknowledge slot
`define I3C_BIT_IDX_W 4

// Receive queue entry tags
`define I3C_ACQ_START 2'b01
`define I3C_ACQ_DATA 2'b00
`define I3C_ACQ_STOP 2'b10
`define I3C_ACQ_NACK_STOP 2'b11

`endif

// File: rtl/i3c_target_pkg.sv
`include "i3c_target_params.svh"

package i3c_target_pkg;

  typedef logic [`I3C_BYTE_W-1:0] bus_byte_t;
  typedef logic [`I3C_ADDR_W-1:0] target_addr_t;
  typedef logic [`I3C_TIMER_W-1:0] tick_count_t;
  // 0..7 are data bits, 8 is the acknowledge slot
  typedef logic [`I3C_BIT_IDX_W-1:0] bit_idx_t;
  typedef logic [1:0] acq_tag_t;

  // Receive queue word
  typedef struct packed {
    acq_tag_t  tag;
    bus_byte_t data;
  } acq_entry_t;

  // Bus view shared by the FSM and the SDA driver
  typedef struct packed {
    logic      scl;
    logic      scl_rise;
    logic      scl_fall;
    bit_idx_t  bit_idx;
    logic      bit_ack;
    logic      byte_strobe;
    bus_byte_t input_byte;
    logic      host_ack;
  } rx_status_t;

  // Single-cycle event pulses
  typedef struct packed {
    logic cmd_complete;
    logic unexp_stop;
    logic target_nack;
    logic read_cmd;
  } target_events_t;

  typedef enum logic [1:0] {
    SdaRelease,
    SdaLow,
    SdaTx
  } sda_mode_e;

  typedef enum logic [3:0] {
    Idle,
    AcquireStart,
    AddrRead,
    AddrAck,
    TransmitWait,
    TransmitBits,
    TransmitAck,
    AcquireByte,
    AcquireAck,
    WaitForStop
  } target_state_e;

endpackage

// File: rtl/hold_timer.sv
`timescale 1ns/1ps

module hold_timer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        load_i,
  input  i3c_target_pkg::tick_count_t delay_i,
  output logic                        expired_o
);

  import i3c_target_pkg::*;

  tick_count_t count_q;

  // Countdown from the loaded delay
  // Parks at zero so a single load gives a single expiry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= delay_i;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Fires on the last count, exactly delay_i cycles after the load
  assign expired_o = (count_q == tick_count_t'(1));

endmodule

// File: rtl/bit_receiver.sv
`timescale 1ns/1ps

`include "i3c_target_params.svh"

module bit_receiver (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  input  logic                       start_i,
  input  logic                       clear_i,
  output i3c_target_pkg::rx_status_t status_o
);

  import i3c_target_pkg::*;

  logic      scl_q;
  logic      sda_q;
  logic      scl_rise_q;
  logic      scl_fall_q;
  bit_idx_t  bit_idx_q;
  logic      bit_ack;
  logic      byte_strobe_q;
  bus_byte_t input_byte_q;
  logic      host_ack_q;

  // Single register stage on the bus lines
  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      scl_rise_q <= 1'b0;
      scl_fall_q <= 1'b0;
    end else begin
      scl_q      <= scl_i;
      sda_q      <= sda_i;
      scl_rise_q <= scl_i & ~scl_q;
      scl_fall_q <= ~scl_i & scl_q;
    end
  end

  assign bit_ack = (bit_idx_q == bit_idx_t'(8));

  // Bit position advances on every SCL fall and wraps after the ack slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= '0;
    end else if (start_i || clear_i) begin
      bit_idx_q <= '0;
    end else if (scl_fall_q) begin
      bit_idx_q <= bit_ack ? '0 : bit_idx_q + 1'b1;
    end
  end

  // MSB first shift of data bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      input_byte_q <= '0;
    end else if (clear_i) begin
      input_byte_q <= '0;
    end else if (scl_rise_q && !bit_ack) begin
      input_byte_q <= {input_byte_q[`I3C_BYTE_W-2:0], sda_q};
    end
  end

  // Strobe trails each data bit sample by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_strobe_q <= 1'b0;
    end else begin
      byte_strobe_q <= scl_rise_q & ~bit_ack;
    end
  end

  // Host ACK is SDA low in the ninth bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q <= 1'b0;
    end else if (scl_rise_q && bit_ack) begin
      host_ack_q <= ~sda_q;
    end
  end

  always_comb begin
    status_o.scl         = scl_q;
    status_o.scl_rise    = scl_rise_q;
    status_o.scl_fall    = scl_fall_q;
    status_o.bit_idx     = bit_idx_q;
    status_o.bit_ack     = bit_ack;
    status_o.byte_strobe = byte_strobe_q;
    status_o.input_byte  = input_byte_q;
    status_o.host_ack    = host_ack_q;
  end

endmodule

// File: rtl/sda_driver.sv
`timescale 1ns/1ps

module sda_driver (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::sda_mode_e  mode_i,
  input  logic                       tx_latch_i,
  input  i3c_target_pkg::bus_byte_t  tx_byte_i,
  input  logic                       tx_valid_i,
  input  i3c_target_pkg::rx_status_t status_i,
  input  logic                       update_i,
  output logic                       sda_o,
  output logic                       transmitting_o,
  output logic                       popped_o
);

  import i3c_target_pkg::*;

  sda_mode_e mode_q;
  bus_byte_t tx_byte_q;
  logic      popped_q;
  logic      sda_q;
  logic      sda_next;

  // Byte to shift out, all ones when the queue is empty
  always_ff @(posedge clk_i) begin
    if (tx_latch_i) begin
      tx_byte_q <= tx_valid_i ? tx_byte_i : '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      popped_q <= 1'b0;
    end else if (tx_latch_i) begin
      popped_q <= tx_valid_i;
    end
  end

  // Bit index 7-i maps to the inverted low bits; ack slot stays released
  always_comb begin
    unique case (mode_i)
      SdaLow:  sda_next = 1'b0;
      SdaTx:   sda_next = status_i.bit_ack ? 1'b1 : tx_byte_q[~status_i.bit_idx[2:0]];
      default: sda_next = 1'b1;
    endcase
  end

  // SDA moves only at a hold expiry or when the mode itself changes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= SdaRelease;
      sda_q  <= 1'b1;
    end else begin
      mode_q <= mode_i;
      if (update_i || (mode_i != mode_q)) begin
        sda_q <= sda_next;
      end
    end
  end

  assign sda_o          = sda_q;
  assign transmitting_o = (mode_q != SdaRelease);
  assign popped_o       = popped_q;

endmodule

// File: rtl/target_fsm.sv
`timescale 1ns/1ps

`include "i3c_target_params.svh"

module target_fsm (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           enable_i,
  input  logic                           start_i,
  input  logic                           stop_i,
  input  i3c_target_pkg::target_addr_t   addr_i,
  input  i3c_target_pkg::rx_status_t     status_i,
  input  logic                           timer_expired_i,
  input  logic                           popped_i,
  input  logic                           rx_wready_i,
  input  logic                           tx_valid_i,
  output logic                           timer_load_o,
  output logic                           clear_o,
  output i3c_target_pkg::sda_mode_e      sda_mode_o,
  output logic                           tx_latch_o,
  output logic                           rx_wvalid_o,
  output i3c_target_pkg::acq_entry_t     rx_wdata_o,
  output logic                           tx_rready_o,
  output logic                           idle_o,
  output i3c_target_pkg::target_events_t events_o
);

  import i3c_target_pkg::*;

  target_state_e state_q, state_d;
  logic      for_us_q, for_us_d;
  logic      nack_q, nack_d;
  logic      rnw_q, rnw_d;
  logic      addr_capture;
  bus_byte_t addr_byte_q;
  logic      stop_pend_q;
  logic      stop_nack_q;
  logic      eighth_fall;
  logic      ninth_fall;
  logic      addr_match;

  assign eighth_fall = status_i.scl_fall && (status_i.bit_idx == bit_idx_t'(7));
  assign ninth_fall  = status_i.scl_fall && status_i.bit_ack;
  assign addr_match  = (status_i.input_byte[`I3C_BYTE_W-1:1] == addr_i);

  always_comb begin
    state_d      = state_q;
    for_us_d     = for_us_q;
    nack_d       = nack_q;
    rnw_d        = rnw_q;
    addr_capture = 1'b0;
    timer_load_o = 1'b0;
    clear_o      = 1'b0;
    sda_mode_o   = SdaRelease;
    tx_latch_o   = 1'b0;
    rx_wvalid_o  = 1'b0;
    rx_wdata_o   = '{tag: `I3C_ACQ_DATA, data: status_i.input_byte};
    tx_rready_o  = 1'b0;
    events_o     = '0;

    unique case (state_q)
      Idle: begin
        for_us_d = 1'b0;
        nack_d   = 1'b0;
      end
      // Start ends on SCL fall; restart the bit count there
      AcquireStart: begin
        if (status_i.scl_fall) begin
          clear_o = 1'b1;
          state_d = AddrRead;
        end
      end
      // Address is complete at the eighth fall
      AddrRead: begin
        if (eighth_fall) begin
          timer_load_o = 1'b1;
          addr_capture = 1'b1;
          rnw_d        = status_i.input_byte[0];
          if (addr_match) begin
            for_us_d = 1'b1;
          end else begin
            state_d = WaitForStop;
          end
        end else if (status_i.bit_ack && timer_expired_i) begin
          state_d = AddrAck;
        end
      end
      // Hold SDA low through the ninth bit
      AddrAck: begin
        sda_mode_o = SdaLow;
        if (ninth_fall) begin
          timer_load_o = 1'b1;
        end else if (timer_expired_i) begin
          rx_wvalid_o       = 1'b1;
          rx_wdata_o        = '{tag: `I3C_ACQ_START, data: addr_byte_q};
          events_o.read_cmd = rnw_q;
          state_d           = rnw_q ? TransmitWait : AcquireByte;
        end
      end
      TransmitWait: begin
        tx_latch_o = 1'b1;
        state_d    = TransmitBits;
      end
      // Each fall starts a hold, the driver shifts the next bit at expiry
      TransmitBits: begin
        sda_mode_o = SdaTx;
        if (status_i.scl_fall) begin
          timer_load_o = 1'b1;
        end else if (timer_expired_i && status_i.bit_ack) begin
          state_d = TransmitAck;
        end
      end
      // Host owns SDA here
      TransmitAck: begin
        if (ninth_fall) begin
          tx_rready_o  = popped_i;
          timer_load_o = 1'b1;
          if (!status_i.host_ack) begin
            state_d = WaitForStop;
          end
        end else if (timer_expired_i) begin
          state_d = TransmitWait;
        end
      end
      // No room in the receive queue means NACK and give up
      AcquireByte: begin
        if (eighth_fall) begin
          timer_load_o = 1'b1;
          if (!rx_wready_i) begin
            nack_d               = 1'b1;
            events_o.target_nack = 1'b1;
            state_d              = WaitForStop;
          end
        end else if (status_i.bit_ack && timer_expired_i) begin
          state_d = AcquireAck;
        end
      end
      AcquireAck: begin
        sda_mode_o = SdaLow;
        if (ninth_fall) begin
          timer_load_o = 1'b1;
        end else if (timer_expired_i) begin
          rx_wvalid_o = 1'b1;
          state_d     = AcquireByte;
        end
      end
      WaitForStop: begin
      end
      default: begin
        state_d = Idle;
      end
    endcase

    // Stop record lands one cycle after the strobe
    if (stop_pend_q) begin
      rx_wvalid_o = 1'b1;
      rx_wdata_o  = '{tag: stop_nack_q ? `I3C_ACQ_NACK_STOP : `I3C_ACQ_STOP,
                      data: addr_byte_q};
    end

    if (!enable_i) begin
      state_d  = Idle;
      for_us_d = 1'b0;
    end else if (start_i) begin
      state_d               = AcquireStart;
      events_o.cmd_complete = for_us_q;
      for_us_d              = 1'b0;
      nack_d                = 1'b0;
    end else if (stop_i) begin
      state_d               = Idle;
      events_o.cmd_complete = for_us_q;
      // A read should end with a host NACK before the stop
      events_o.unexp_stop   = for_us_q & rnw_q & (state_q != WaitForStop);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      for_us_q    <= 1'b0;
      nack_q      <= 1'b0;
      rnw_q       <= 1'b0;
      stop_pend_q <= 1'b0;
      stop_nack_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      for_us_q    <= for_us_d;
      nack_q      <= nack_d;
      rnw_q       <= rnw_d;
      stop_pend_q <= enable_i & stop_i & for_us_q;
      stop_nack_q <= nack_q;
    end
  end

  // Address byte kept for the start and stop records
  always_ff @(posedge clk_i) begin
    if (addr_capture) begin
      addr_byte_q <= status_i.input_byte;
    end
  end

  assign idle_o = (state_q == Idle);

endmodule

// File: rtl/i3c_target.sv
`timescale 1ns/1ps

module i3c_target (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           target_enable_i,
  input  logic                           scl_i,
  input  logic                           sda_i,
  input  logic                           bus_start_det_i,
  input  logic                           bus_stop_det_i,
  input  i3c_target_pkg::target_addr_t   target_addr_i,
  input  i3c_target_pkg::tick_count_t    thd_dat_i,
  input  logic                           tx_fifo_rvalid_i,
  input  i3c_target_pkg::bus_byte_t      tx_fifo_rdata_i,
  output logic                           tx_fifo_rready_o,
  output logic                           rx_fifo_wvalid_o,
  output i3c_target_pkg::acq_entry_t     rx_fifo_wdata_o,
  input  logic                           rx_fifo_wready_i,
  output logic                           sda_o,
  output logic                           target_idle_o,
  output logic                           target_transmitting_o,
  output i3c_target_pkg::target_events_t events_o
);

  import i3c_target_pkg::*;

  rx_status_t rx_status;
  sda_mode_e  sda_mode;
  logic       timer_load;
  logic       timer_expired;
  logic       rx_clear;
  logic       tx_latch;
  logic       tx_popped;

  // Hold delay between SCL fall and SDA change
  hold_timer u_hold_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (timer_load),
    .delay_i   (thd_dat_i),
    .expired_o (timer_expired)
  );

  bit_receiver u_bit_receiver (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .scl_i    (scl_i),
    .sda_i    (sda_i),
    .start_i  (bus_start_det_i),
    .clear_i  (rx_clear),
    .status_o (rx_status)
  );

  sda_driver u_sda_driver (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mode_i         (sda_mode),
    .tx_latch_i     (tx_latch),
    .tx_byte_i      (tx_fifo_rdata_i),
    .tx_valid_i     (tx_fifo_rvalid_i),
    .status_i       (rx_status),
    .update_i       (timer_expired),
    .sda_o          (sda_o),
    .transmitting_o (target_transmitting_o),
    .popped_o       (tx_popped)
  );

  target_fsm u_target_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .enable_i        (target_enable_i),
    .start_i         (bus_start_det_i),
    .stop_i          (bus_stop_det_i),
    .addr_i          (target_addr_i),
    .status_i        (rx_status),
    .timer_expired_i (timer_expired),
    .popped_i        (tx_popped),
    .rx_wready_i     (rx_fifo_wready_i),
    .tx_valid_i      (tx_fifo_rvalid_i),
    .timer_load_o    (timer_load),
    .clear_o         (rx_clear),
    .sda_mode_o      (sda_mode),
    .tx_latch_o      (tx_latch),
    .rx_wvalid_o     (rx_fifo_wvalid_o),
    .rx_wdata_o      (rx_fifo_wdata_o),
    .tx_rready_o     (tx_fifo_rready_o),
    .idle_o          (target_idle_o),
    .events_o        (events_o)
  );

endmodule

// File: verification/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Counts every check, one line per mismatch
task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("MISMATCH %0t ns %s: got 0x%0h, expected 0x%0h",
             $time, name, actual, expected);
  end
endtask

// SDA falls while SCL is high, then the detector strobe
// Leaves SCL low, ready for the first bit
task automatic issue_start();
  @(posedge clk_i);
  sda_h <= 1'b1;
  scl   <= 1'b1;
  repeat (4) @(posedge clk_i);
  sda_h <= 1'b0;
  repeat (2) @(posedge clk_i);
  start_det <= 1'b1;
  @(posedge clk_i);
  start_det <= 1'b0;
  repeat (4) @(posedge clk_i);
  scl <= 1'b0;
endtask

// SDA rises while SCL is high, entered with SCL low
task automatic issue_stop();
  repeat (4) @(posedge clk_i);
  sda_h <= 1'b0;
  repeat (4) @(posedge clk_i);
  scl <= 1'b1;
  repeat (4) @(posedge clk_i);
  sda_h <= 1'b1;
  repeat (2) @(posedge clk_i);
  stop_det <= 1'b1;
  @(posedge clk_i);
  stop_det <= 1'b0;
  repeat (4) @(posedge clk_i);
endtask

// One SCL period of 16 clocks
// Host level set mid-low, DUT SDA sampled mid-high
task automatic clock_bit(input logic drive, output logic seen);
  repeat (4) @(posedge clk_i);
  sda_h <= drive;
  repeat (4) @(posedge clk_i);
  scl <= 1'b1;
  repeat (4) @(posedge clk_i);
  @(negedge clk_i);
  seen = dut_sda;
  repeat (4) @(posedge clk_i);
  scl <= 1'b0;
endtask

// MSB first, host releases SDA for the ack slot
task automatic write_byte(input bus_byte_t b, output logic acked);
  logic seen;
  int   i;
  for (i = 7; i >= 0; i--) begin
    clock_bit(b[i], seen);
  end
  clock_bit(1'b1, seen);
  acked = ~seen;
endtask

// Host keeps SDA released, then answers ACK or NACK
task automatic read_byte(input logic ack, output bus_byte_t b);
  logic seen;
  int   i;
  for (i = 7; i >= 0; i--) begin
    clock_bit(1'b1, seen);
    b[i] = seen;
  end
  clock_bit(~ack, seen);
endtask

`endif

// File: verification/tb_i3c_target.sv
`timescale 1ns/1ps

`include "i3c_target_params.svh"

module tb_i3c_target;

  import i3c_target_pkg::*;

  localparam target_addr_t OUR_ADDR   = 7'h2a;
  localparam target_addr_t OTHER_ADDR = 7'h51;
  localparam tick_count_t  HOLD       = 2;

  logic           clk_i;
  logic           rst_ni;
  logic           enable;
  logic           scl;
  logic           sda_h;
  logic           start_det;
  logic           stop_det;
  logic           rx_wready;
  logic           tx_rready;
  logic           rx_wvalid;
  acq_entry_t     rx_wdata;
  logic           dut_sda;
  logic           idle;
  logic           transmitting;
  target_events_t events;

  // Transmit queue model whose head advances on each pop
  bus_byte_t tx_mem [0:31];
  int        tx_cnt = 0;
  int        tx_head = 0;

  // Everything the DUT wrote into the receive queue
  acq_entry_t rx_log [$];

  int checks = 0;
  int errors = 0;
  int cc_cnt = 0;
  int unexp_cnt = 0;
  int nack_cnt = 0;
  int rd_cnt = 0;
  int pop_cnt = 0;
  int low_cnt = 0;
  int xmit_cnt = 0;
  int ev_cnt = 0;

  always #20 clk_i = ~clk_i;

  // Open-drain bus where either side pulls SDA low
  i3c_target uut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .target_enable_i       (enable),
    .scl_i                 (scl),
    .sda_i                 (sda_h & dut_sda),
    .bus_start_det_i       (start_det),
    .bus_stop_det_i        (stop_det),
    .target_addr_i         (OUR_ADDR),
    .thd_dat_i             (HOLD),
    .tx_fifo_rvalid_i      (tx_head < tx_cnt),
    .tx_fifo_rdata_i       (tx_mem[tx_head % 32]),
    .tx_fifo_rready_o      (tx_rready),
    .rx_fifo_wvalid_o      (rx_wvalid),
    .rx_fifo_wdata_o       (rx_wdata),
    .rx_fifo_wready_i      (rx_wready),
    .sda_o                 (dut_sda),
    .target_idle_o         (idle),
    .target_transmitting_o (transmitting),
    .events_o              (events)
  );

  always @(posedge clk_i) begin
    if (tx_rready) begin
      tx_head <= tx_head + 1;
    end
  end

  // Mid-cycle monitor of queue strobes, events and bus activity
  always @(negedge clk_i) begin
    if (rx_wvalid) begin
      rx_log.push_back(rx_wdata);
    end
    if (events.cmd_complete) cc_cnt++;
    if (events.unexp_stop) unexp_cnt++;
    if (events.target_nack) nack_cnt++;
    if (events.read_cmd) rd_cnt++;
    if (events != '0) ev_cnt++;
    if (tx_rready) pop_cnt++;
    if (!dut_sda) low_cnt++;
    if (transmitting) xmit_cnt++;
  end

  `include "tb_bus_tasks.svh"

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR %0t ns: %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int err_base);
    $display("%-16s %0d error(s)", name, errors - err_base);
  endtask

  task automatic push_tx(input bus_byte_t b);
    @(posedge clk_i);
    tx_mem[tx_cnt % 32] <= b;
    tx_cnt <= tx_cnt + 1;
  endtask

  task automatic wait_entries(input int want);
    int n;
    n = 0;
    while (rx_log.size() < want && n < 400) begin
      @(posedge clk_i);
      n++;
    end
    if (rx_log.size() < want) flag_error("timeout waiting for receive queue entries");
  endtask

  // Expects a start entry, one data entry per byte and a stop entry
  task automatic test_private_write();
    bus_byte_t data [3];
    bus_byte_t addr_byte;
    logic      acked;
    int        err_base;
    int        log_base;
    int        cc_base;
    int        i;
    err_base  = errors;
    log_base  = rx_log.size();
    cc_base   = cc_cnt;
    addr_byte = {OUR_ADDR, 1'b0};
    for (i = 0; i < 3; i++) data[i] = bus_byte_t'($urandom);
    issue_start();
    write_byte(addr_byte, acked);
    check_value("address ack", acked, 1'b1);
    for (i = 0; i < 3; i++) begin
      write_byte(data[i], acked);
      check_value("data ack", acked, 1'b1);
    end
    issue_stop();
    wait_entries(log_base + 5);
    check_value("receive entry count", rx_log.size() - log_base, 5);
    if (rx_log.size() == log_base + 5) begin
      check_value("rx_fifo_wdata_o", rx_log[log_base], {`I3C_ACQ_START, addr_byte});
      for (i = 0; i < 3; i++) begin
        check_value("rx_fifo_wdata_o", rx_log[log_base + 1 + i], {`I3C_ACQ_DATA, data[i]});
      end
      check_value("rx_fifo_wdata_o", rx_log[log_base + 4], {`I3C_ACQ_STOP, addr_byte});
    end
    check_value("cmd_complete pulses", cc_cnt - cc_base, 1);
    finish_test("private write", err_base);
  endtask

  // Host ACKs all but the last byte
  task automatic test_private_read();
    bus_byte_t exp_b [3];
    bus_byte_t got;
    logic      acked;
    int        err_base;
    int        pop_base;
    int        unexp_base;
    int        rd_base;
    int        xmit_base;
    int        i;
    err_base   = errors;
    pop_base   = pop_cnt;
    unexp_base = unexp_cnt;
    rd_base    = rd_cnt;
    xmit_base  = xmit_cnt;
    for (i = 0; i < 3; i++) begin
      exp_b[i] = bus_byte_t'($urandom);
      push_tx(exp_b[i]);
    end
    issue_start();
    write_byte({OUR_ADDR, 1'b1}, acked);
    check_value("address ack", acked, 1'b1);
    for (i = 0; i < 3; i++) begin
      read_byte(i < 2, got);
      check_value("sda_o byte", got, exp_b[i]);
    end
    issue_stop();
    check_value("tx_fifo_rready_o pops", pop_cnt - pop_base, 3);
    check_value("unexp_stop pulses", unexp_cnt - unexp_base, 0);
    check_value("read_cmd pulses", rd_cnt - rd_base, 1);
    // Target owns SDA while it shifts out data
    check_value("target_transmitting_o active", (xmit_cnt - xmit_base) > 0, 1'b1);
    finish_test("private read", err_base);
  endtask

  // DUT must stay silent on the bus and in its outputs
  task automatic test_other_address();
    logic acked;
    int   err_base;
    int   log_base;
    int   low_base;
    int   xmit_base;
    int   ev_base;
    err_base  = errors;
    log_base  = rx_log.size();
    low_base  = low_cnt;
    xmit_base = xmit_cnt;
    ev_base   = ev_cnt;
    issue_start();
    write_byte({OTHER_ADDR, 1'b0}, acked);
    check_value("address ack", acked, 1'b0);
    write_byte(bus_byte_t'($urandom), acked);
    check_value("data ack", acked, 1'b0);
    issue_stop();
    check_value("sda_o low cycles", low_cnt - low_base, 0);
    check_value("target_transmitting_o cycles", xmit_cnt - xmit_base, 0);
    check_value("receive entry count", rx_log.size() - log_base, 0);
    check_value("event pulses", ev_cnt - ev_base, 0);
    finish_test("other address", err_base);
  endtask

  // Receive queue full on the second data byte
  task automatic test_back_pressure();
    bus_byte_t data [2];
    bus_byte_t addr_byte;
    logic      acked;
    int        err_base;
    int        log_base;
    int        nack_base;
    err_base  = errors;
    log_base  = rx_log.size();
    nack_base = nack_cnt;
    addr_byte = {OUR_ADDR, 1'b0};
    data[0]   = bus_byte_t'($urandom);
    data[1]   = bus_byte_t'($urandom);
    issue_start();
    write_byte(addr_byte, acked);
    write_byte(data[0], acked);
    check_value("first data ack", acked, 1'b1);
    @(posedge clk_i);
    rx_wready <= 1'b0;
    write_byte(data[1], acked);
    check_value("second data ack", acked, 1'b0);
    issue_stop();
    rx_wready <= 1'b1;
    wait_entries(log_base + 3);
    check_value("receive entry count", rx_log.size() - log_base, 3);
    if (rx_log.size() == log_base + 3) begin
      check_value("rx_fifo_wdata_o", rx_log[log_base], {`I3C_ACQ_START, addr_byte});
      check_value("rx_fifo_wdata_o", rx_log[log_base + 1], {`I3C_ACQ_DATA, data[0]});
      check_value("rx_fifo_wdata_o", rx_log[log_base + 2], {`I3C_ACQ_NACK_STOP, addr_byte});
    end
    check_value("target_nack pulses", nack_cnt - nack_base, 1);
    finish_test("back-pressure", err_base);
  endtask

  // Stop right after a host ACK while the next byte is already on the bus
  task automatic test_unexpected_stop();
    bus_byte_t first;
    bus_byte_t got;
    logic      acked;
    int        err_base;
    int        unexp_base;
    err_base   = errors;
    unexp_base = unexp_cnt;
    first      = bus_byte_t'($urandom);
    push_tx(first);
    push_tx(bus_byte_t'($urandom));
    issue_start();
    write_byte({OUR_ADDR, 1'b1}, acked);
    read_byte(1'b1, got);
    check_value("sda_o byte", got, first);
    issue_stop();
    check_value("unexp_stop pulses", unexp_cnt - unexp_base, 1);
    finish_test("unexpected stop", err_base);
  endtask

  // Enable drops while the DUT holds SDA low for a data ack
  task automatic test_disable();
    bus_byte_t data;
    logic      acked;
    logic      seen;
    int        err_base;
    int        n;
    int        i;
    err_base = errors;
    data     = bus_byte_t'($urandom);
    issue_start();
    write_byte({OUR_ADDR, 1'b0}, acked);
    for (i = 7; i >= 0; i--) clock_bit(data[i], seen);
    // Outputs are sampled mid-cycle, away from the clock edge
    n = 0;
    while (dut_sda !== 1'b0 && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (dut_sda !== 1'b0) flag_error("timeout waiting for the DUT to drive the data ack");
    @(posedge clk_i);
    enable <= 1'b0;
    n = 0;
    while (!(idle === 1'b1 && dut_sda === 1'b1) && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (!(idle === 1'b1 && dut_sda === 1'b1)) flag_error("timeout waiting for idle after disable");
    check_value("target_idle_o", idle, 1'b1);
    check_value("sda_o", dut_sda, 1'b1);
    issue_stop();
    enable <= 1'b1;
    finish_test("disable", err_base);
  endtask

  initial begin
    int seed;
    seed = 32'hdd20;
    void'($urandom(seed));
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    enable    = 1'b1;
    scl       = 1'b1;
    sda_h     = 1'b1;
    start_det = 1'b0;
    stop_det  = 1'b0;
    rx_wready = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);
    test_private_write();
    test_private_read();
    test_other_address();
    test_back_pressure();
    test_unexpected_stop();
    test_disable();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+rtl
+incdir+verification
rtl/i3c_target_pkg.sv
rtl/hold_timer.sv
rtl/bit_receiver.sv
rtl/sda_driver.sv
rtl/target_fsm.sv
rtl/i3c_target.sv
verification/tb_i3c_target.sv

// File: Bender.yml
package:
  name: i3c_target

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/i3c_target_pkg.sv
      - rtl/hold_timer.sv
      - rtl/bit_receiver.sv
      - rtl/sda_driver.sv
      - rtl/target_fsm.sv
      - rtl/i3c_target.sv
  - target: test
    include_dirs:
      - rtl
      - verification
    files:
      - verification/tb_i3c_target.sv
